//--- rtl/main_board_defs.svh
// Shared constants for the main-CPU bus side of the board
// Included by the RTL files that size the sound FIFO, decode regions
// or drive the open-bus value
`ifndef MAIN_BOARD_DEFS_SVH
`define MAIN_BOARD_DEFS_SVH

// Main-to-sound command FIFO
`define SND_FIFO_DEPTH 4
`define SND_FIFO_AW    2    // Depth is 2**AW

// Returned for unmapped reads
`define OPEN_BUS 16'hffff

// Address bits that select the memory region
`define REGION_MSB 23
`define REGION_LSB 20

`endif

//--- rtl/main_board_pkg.sv
// Types shared by the main board bus blocks and the testbench
// Bus access, registered decode, cabinet inputs and the control latch
package main_board_pkg;

    // One 68000 access with a single-cycle acc strobe
    typedef struct packed {
        logic        acc;
        logic        rnw;
        logic [23:1] addr;
        logic [1:0]  dsn;
        logic [15:0] dout;
    } main_bus_t;

    typedef enum logic [2:0] {
        REG_ROM  = 3'd0,
        REG_RAM  = 3'd1,
        REG_PAL  = 3'd2,
        REG_OBJ  = 3'd3,
        REG_IO   = 3'd4,
        REG_SUB  = 3'd5,
        REG_NONE = 3'd7
    } region_e;

    // Select from addr[6:4] inside REG_IO
    typedef enum logic [2:0] {
        IO_SWITCH = 3'd0,
        IO_CTRL   = 3'd1,
        IO_NONE   = 3'd2,   // Also stands for 4
        IO_ADC    = 3'd3,
        IO_SND    = 3'd5,
        IO_REPLY  = 3'd6,
        IO_OBJTOG = 3'd7
    } io_sel_e;

    typedef struct packed {
        logic        valid;
        logic        rnw;
        region_e     region;
        io_sel_e     io_sel;
        logic [1:0]  sub;       // addr[2:1]
        logic [19:1] addr;
        logic [1:0]  dsn;
        logic [15:0] dout;
    } dec_t;

    typedef struct packed {
        logic [7:0]  joystick;  // Active low
        logic        start;
        logic [1:0]  coin;
        logic        service;
        logic        dip_test;
        logic [7:0]  dipsw_a;
        logic [7:0]  dipsw_b;
        logic [7:0]  wheel;
        logic [15:0] pedal;     // Gas high byte, brake low byte
    } cab_in_t;

    typedef struct packed {
        logic       video_en;
        logic       snd_rstb;
        logic [2:0] adc_ch;
    } board_ctrl_t;

endpackage

//--- rtl/main_bus_decode.sv
// Memory-map decoder for the main CPU
// Registers every access one cycle after its strobe, producing the
// external chip selects, the memory address and a decode record for
// the internal I/O blocks
`include "main_board_defs.svh"

module main_bus_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  main_board_pkg::main_bus_t bus,
    output main_board_pkg::dec_t     dec,
    output logic                     rom_cs,
    output logic                     ram_cs,
    output logic                     pal_cs,
    output logic                     obj_cs,
    output logic                     sub_cs,
    output logic [19:1]              mem_addr
);

    main_board_pkg::region_e region_d;
    main_board_pkg::io_sel_e io_d;
    main_board_pkg::dec_t    dec_d;
    main_board_pkg::dec_t    dec_pay;   // Access fields
    logic                    dec_valid;

    always_comb begin
        case (bus.addr[`REGION_MSB:`REGION_LSB])
            4'd0:    region_d = main_board_pkg::REG_ROM;
            4'd1:    region_d = main_board_pkg::REG_RAM;
            4'd2:    region_d = main_board_pkg::REG_PAL;
            4'd3:    region_d = main_board_pkg::REG_OBJ;
            4'd4:    region_d = main_board_pkg::REG_IO;
            4'd5:    region_d = main_board_pkg::REG_SUB;
            default: region_d = main_board_pkg::REG_NONE;
        endcase

        case (bus.addr[6:4])
            3'd0:    io_d = main_board_pkg::IO_SWITCH;
            3'd1:    io_d = main_board_pkg::IO_CTRL;
            3'd3:    io_d = main_board_pkg::IO_ADC;
            3'd5:    io_d = main_board_pkg::IO_SND;
            3'd6:    io_d = main_board_pkg::IO_REPLY;
            3'd7:    io_d = main_board_pkg::IO_OBJTOG;
            default: io_d = main_board_pkg::IO_NONE;
        endcase
        if (region_d != main_board_pkg::REG_IO) begin
            io_d = main_board_pkg::IO_NONE;   // I/O select only inside the I/O window
        end
    end

    always_comb begin
        dec_d.valid  = bus.acc;
        dec_d.rnw    = bus.rnw;
        dec_d.region = region_d;
        dec_d.io_sel = io_d;
        dec_d.sub    = bus.addr[2:1];
        dec_d.addr   = bus.addr[19:1];
        dec_d.dsn    = bus.dsn;
        dec_d.dout   = bus.dout;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            pal_cs    <= 1'b0;
            obj_cs    <= 1'b0;
            sub_cs    <= 1'b0;
        end else begin
            dec_valid <= bus.acc;
            rom_cs    <= bus.acc && region_d == main_board_pkg::REG_ROM;
            ram_cs    <= bus.acc && region_d == main_board_pkg::REG_RAM;
            pal_cs    <= bus.acc && region_d == main_board_pkg::REG_PAL;
            obj_cs    <= bus.acc && region_d == main_board_pkg::REG_OBJ;
            sub_cs    <= bus.acc && region_d == main_board_pkg::REG_SUB;
        end
    end

    always_ff @(posedge clk) begin
        dec_pay <= dec_d;
    end

    always_comb begin
        dec       = dec_pay;
        dec.valid = dec_valid;
    end

    assign mem_addr = dec_pay.addr;  // Same stage as the chip selects

    // External memories share one data return path
    a_cs_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, pal_cs, obj_cs, sub_cs}));

endmodule

//--- rtl/cab_io.sv
// Cabinet I/O for the main CPU
// Answers switch, DIP, ADC, sound status and reply reads from the
// registered decode, holds the board control latch and pulses the
// object buffer toggle
module cab_io (
    input  logic                        clk,
    input  logic                        rst,
    input  main_board_pkg::dec_t        dec,
    input  main_board_pkg::cab_in_t     cab,
    input  logic                        fifo_full,
    input  logic [2:0]                  fifo_count,
    input  logic [7:0]                  reply,
    output logic [7:0]                  io_rdata,
    output main_board_pkg::board_ctrl_t ctrl,
    output logic                        obj_toggle
);

    logic [7:0] sys_byte;
    logic [7:0] adc_byte;
    logic [7:0] gas;
    logic [7:0] brake;
    logic       io_acc;
    logic       ctrl_wr;

    assign io_acc  = dec.valid && dec.region == main_board_pkg::REG_IO;
    assign ctrl_wr = io_acc && !dec.rnw && dec.io_sel == main_board_pkg::IO_CTRL;

    assign gas   = cab.pedal[15:8];
    assign brake = cab.pedal[7:0];

    // Low bits are unused inputs and float high
    assign sys_byte = {cab.coin, cab.start, cab.service, cab.dip_test, 3'b111};

    // Joystick bits override the analog values
    always_comb begin
        case (ctrl.adc_ch)
            3'd0: begin
                if (!cab.joystick[0]) begin
                    adc_byte = 8'h20;
                end else if (!cab.joystick[1]) begin
                    adc_byte = 8'hd0;
                end else begin
                    adc_byte = cab.wheel ^ 8'h80;   // Center at 0x80
                end
            end
            3'd1:    adc_byte = !cab.joystick[5] ? 8'hff : gas;
            3'd2:    adc_byte = !cab.joystick[6] ? 8'hff : brake;
            default: adc_byte = 8'h00;
        endcase
    end

    always_comb begin
        io_rdata = 8'hff;
        if (dec.region == main_board_pkg::REG_IO) begin
            case (dec.io_sel)
                main_board_pkg::IO_SWITCH: begin
                    case (dec.sub)
                        2'd0:    io_rdata = sys_byte;
                        2'd1:    io_rdata = 8'hff;
                        2'd2:    io_rdata = cab.dipsw_a;
                        default: io_rdata = cab.dipsw_b;
                    endcase
                end
                main_board_pkg::IO_ADC:   io_rdata = adc_byte;
                main_board_pkg::IO_SND:   io_rdata = {fifo_full, 4'b0000, fifo_count};
                main_board_pkg::IO_REPLY: io_rdata = reply;
                default:                  io_rdata = 8'hff;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl.video_en <= 1'b1;
            ctrl.snd_rstb <= 1'b1;   // Sound CPU running
            ctrl.adc_ch   <= 3'd0;
        end else if (ctrl_wr) begin
            ctrl.video_en <= dec.dout[5];
            ctrl.adc_ch   <= dec.dout[4:2];
            ctrl.snd_rstb <= dec.dout[0];
        end
    end

    // Read or write both flip the object buffer
    assign obj_toggle = io_acc && dec.io_sel == main_board_pkg::IO_OBJTOG;

    // One buffer flip per toggle access
    a_toggle_pulse: assert property (@(posedge clk) disable iff (rst)
        obj_toggle |=> !obj_toggle);

endmodule

//--- rtl/snd_cmd_fifo.sv
// Command FIFO from the main CPU to the sound CPU
// Pushed by decoded writes to the sound command port, popped by the
// sound side; a push while full is dropped
`include "main_board_defs.svh"

module snd_cmd_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  main_board_pkg::dec_t dec,
    input  logic                 pop,
    output logic [7:0]           head,
    output logic                 full,
    output logic                 empty,
    output logic [2:0]           count
);

    localparam int DEPTH = `SND_FIFO_DEPTH;
    localparam int AW    = `SND_FIFO_AW;

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   cnt;
    logic          push;

    assign push = dec.valid && !dec.rnw && dec.region == main_board_pkg::REG_IO &&
                  dec.io_sel == main_board_pkg::IO_SND && !full;

    assign full  = cnt[AW];        // Count equals depth
    assign empty = cnt == '0;
    assign count = cnt;
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= dec.dout[7:0];
    end

    // The sound port must check empty before popping
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule

//--- rtl/snd_port.sv
// Sound CPU side of the command path
// Turns the sound read strobe into a FIFO pop with a registered data
// byte, and keeps the reply byte that the main CPU reads back
module snd_port (
    input  logic       clk,
    input  logic       rst,
    input  logic       snd_rd,
    input  logic       snd_wr,
    input  logic [7:0] snd_din,
    input  logic [7:0] head,
    input  logic       empty,
    output logic       pop,
    output logic [7:0] snd_dout,
    output logic       snd_pending,
    output logic [7:0] reply
);

    assign pop         = snd_rd && !empty;
    assign snd_pending = !empty;   // Tells the sound CPU a command waits

    // Held until the next read strobe
    always_ff @(posedge clk) begin
        if (snd_rd) begin
            snd_dout <= empty ? 8'hff : head;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reply <= 8'h00;
        end else if (snd_wr) begin
            reply <= snd_din;
        end
    end

endmodule

//--- rtl/bus_read_mux.sv
// Read data path back to the main CPU
// The source is chosen from the decode and registered; external memory
// data arrives one cycle after its chip select and is muxed in then,
// so rdata and rd_valid line up two cycles after the strobe
`include "main_board_defs.svh"

module bus_read_mux (
    input  logic                 clk,
    input  logic                 rst,
    input  main_board_pkg::dec_t dec,
    input  logic [15:0]          ext_din,
    input  logic [7:0]           io_rdata,
    output logic [15:0]          rdata,
    output logic                 rd_valid
);

    logic        ext_src;
    logic        ext_sel;
    logic [15:0] local_d;
    logic [15:0] local_q;

    always_comb begin
        ext_src = 1'b0;
        local_d = `OPEN_BUS;
        case (dec.region)
            main_board_pkg::REG_ROM,
            main_board_pkg::REG_RAM,
            main_board_pkg::REG_PAL,
            main_board_pkg::REG_OBJ,
            main_board_pkg::REG_SUB: ext_src = 1'b1;
            main_board_pkg::REG_IO: begin
                case (dec.io_sel)
                    main_board_pkg::IO_SWITCH,
                    main_board_pkg::IO_ADC,
                    main_board_pkg::IO_SND,
                    main_board_pkg::IO_REPLY: local_d = {8'hff, io_rdata};
                    default:                  local_d = `OPEN_BUS;
                endcase
            end
            default: local_d = `OPEN_BUS;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
            ext_sel  <= 1'b0;
        end else begin
            rd_valid <= dec.valid && dec.rnw;
            ext_sel  <= dec.valid && dec.rnw && ext_src;
        end
    end

    always_ff @(posedge clk) begin
        local_q <= local_d;
    end

    assign rdata = ext_sel ? ext_din : local_q;

endmodule

//--- rtl/main_board_top.sv
// Main-CPU bus side of the racing board
// The CPU bus enters the decoder; external memories answer through
// ext_din, cabinet I/O and the sound command path are handled on board
module main_board_top (
    input  logic                        clk,
    input  logic                        rst,
    input  main_board_pkg::main_bus_t   bus,
    input  main_board_pkg::cab_in_t     cab,
    input  logic [15:0]                 ext_din,
    output logic                        rom_cs,
    output logic                        ram_cs,
    output logic                        pal_cs,
    output logic                        obj_cs,
    output logic                        sub_cs,
    output logic [19:1]                 mem_addr,
    output logic [15:0]                 rdata,
    output logic                        rd_valid,
    output main_board_pkg::board_ctrl_t ctrl,
    output logic                        obj_toggle,
    input  logic                        snd_rd,
    input  logic                        snd_wr,
    input  logic [7:0]                  snd_din,
    output logic [7:0]                  snd_dout,
    output logic                        snd_pending
);

    main_board_pkg::dec_t dec;
    logic [7:0]           io_rdata;
    logic [7:0]           head;
    logic [7:0]           reply;
    logic [2:0]           fifo_count;
    logic                 fifo_full;
    logic                 fifo_empty;
    logic                 pop;

    main_bus_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .dec      (dec),
        .rom_cs   (rom_cs),
        .ram_cs   (ram_cs),
        .pal_cs   (pal_cs),
        .obj_cs   (obj_cs),
        .sub_cs   (sub_cs),
        .mem_addr (mem_addr)
    );

    cab_io u_cab_io (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .cab        (cab),
        .fifo_full  (fifo_full),
        .fifo_count (fifo_count),
        .reply      (reply),
        .io_rdata   (io_rdata),
        .ctrl       (ctrl),
        .obj_toggle (obj_toggle)
    );

    snd_cmd_fifo u_snd_fifo (
        .clk   (clk),
        .rst   (rst),
        .dec   (dec),
        .pop   (pop),
        .head  (head),
        .full  (fifo_full),
        .empty (fifo_empty),
        .count (fifo_count)
    );

    snd_port u_snd_port (
        .clk         (clk),
        .rst         (rst),
        .snd_rd      (snd_rd),
        .snd_wr      (snd_wr),
        .snd_din     (snd_din),
        .head        (head),
        .empty       (fifo_empty),
        .pop         (pop),
        .snd_dout    (snd_dout),
        .snd_pending (snd_pending),
        .reply       (reply)
    );

    bus_read_mux u_read_mux (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec),
        .ext_din  (ext_din),
        .io_rdata (io_rdata),
        .rdata    (rdata),
        .rd_valid (rd_valid)
    );

endmodule

//--- sim/main_board_tb.sv
// Testbench for the main-CPU bus side of the racing board
// Drives CPU accesses and sound-CPU strobes, models the external
// memories, and checks every read, chip select, latch and FIFO status
// against a reference model kept in the testbench
`include "main_board_defs.svh"

module main_board_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 3000;   // Stimulus is about 700 cycles

    logic clk = 1'b0;
    logic rst;
    main_board_pkg::main_bus_t   bus;
    main_board_pkg::cab_in_t     cab;
    logic [15:0]                 ext_din = '0;
    logic                        rom_cs, ram_cs, pal_cs, obj_cs, sub_cs;
    logic [19:1]                 mem_addr;
    logic [15:0]                 rdata;
    logic                        rd_valid;
    main_board_pkg::board_ctrl_t ctrl;
    logic                        obj_toggle;
    logic                        snd_rd, snd_wr, snd_pending;
    logic [7:0]                  snd_din, snd_dout;

    // Inputs as seen by the DUT at the last rising edge
    main_board_pkg::main_bus_t stage1 = '0;
    main_board_pkg::cab_in_t   cab_q = '0;
    logic                      snd_rd_s = 1'b0;
    logic                      snd_wr_s = 1'b0;
    logic [7:0]                snd_din_s = '0;
    int                        cycles = 0;

    // Reference model state
    main_board_pkg::board_ctrl_t m_ctrl = '{video_en: 1'b1, snd_rstb: 1'b1, adc_ch: 3'd0};
    logic [7:0]                  m_fifo[$];
    logic [7:0]                  m_reply = 8'h00;
    main_board_pkg::main_bus_t   rd_q[$];
    int                          due_q[$];

    main_board_top UUT (
        .clk(clk), .rst(rst), .bus(bus), .cab(cab), .ext_din(ext_din),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .pal_cs(pal_cs), .obj_cs(obj_cs),
        .sub_cs(sub_cs), .mem_addr(mem_addr), .rdata(rdata), .rd_valid(rd_valid),
        .ctrl(ctrl), .obj_toggle(obj_toggle), .snd_rd(snd_rd), .snd_wr(snd_wr),
        .snd_din(snd_din), .snd_dout(snd_dout), .snd_pending(snd_pending)
    );

    always #10 clk = ~clk;

    // Fill pattern covering the whole word address and the region
    function automatic logic [15:0] mem_word(input logic [2:0] rgn, input logic [19:1] a);
        return a[16:1] ^ {a[19:17], 10'h000, rgn};
    endfunction

    // Expected CPU read data for one access
    function automatic logic [15:0] expected_rdata(input main_board_pkg::main_bus_t a,
                                                   input main_board_pkg::cab_in_t c);
        logic [3:0] r;
        logic [7:0] io;
        r = a.addr[23:20];
        if (r <= 4'd5 && r != 4'd4) begin
            return mem_word(r[2:0], a.addr[19:1]);
        end
        if (r != 4'd4) begin
            return `OPEN_BUS;   // Unmapped region
        end
        case (a.addr[6:4])
            3'd0: begin
                case (a.addr[2:1])
                    2'd0:    io = {c.coin, c.start, c.service, c.dip_test, 3'b111};
                    2'd1:    io = 8'hff;
                    2'd2:    io = c.dipsw_a;
                    default: io = c.dipsw_b;
                endcase
            end
            3'd3: begin
                case (m_ctrl.adc_ch)
                    3'd0:    io = !c.joystick[0] ? 8'h20 : !c.joystick[1] ? 8'hd0 :
                                  c.wheel ^ 8'h80;
                    3'd1:    io = !c.joystick[5] ? 8'hff : c.pedal[15:8];
                    3'd2:    io = !c.joystick[6] ? 8'hff : c.pedal[7:0];
                    default: io = 8'h00;
                endcase
            end
            3'd5:    io = {m_fifo.size() == `SND_FIFO_DEPTH, 4'b0000, 3'(m_fifo.size())};
            3'd6:    io = m_reply;
            default: return `OPEN_BUS;
        endcase
        return {8'hff, io};
    endfunction

    // Chip selects as {rom, ram, pal, obj, sub}
    function automatic logic [4:0] cs_for(input main_board_pkg::main_bus_t a);
        if (!a.acc) begin
            return 5'b00000;
        end
        case (a.addr[23:20])
            4'd0:    return 5'b10000;
            4'd1:    return 5'b01000;
            4'd2:    return 5'b00100;
            4'd3:    return 5'b00010;
            4'd5:    return 5'b00001;
            default: return 5'b00000;
        endcase
    endfunction

    function automatic logic [23:1] io_addr(input logic [2:0] sel, input logic [1:0] sub);
        logic [23:1] a;
        a = 23'($urandom());   // Unused bits random
        a[23:20] = 4'h4;
        a[6:4] = sel;
        a[2:1] = sub;
        return a;
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_rdata(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ctrl(input main_board_pkg::board_ctrl_t got,
                              input main_board_pkg::board_ctrl_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns control latch: got %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        stage1    <= bus;
        cab_q     <= cab;
        snd_rd_s  <= snd_rd;
        snd_wr_s  <= snd_wr;
        snd_din_s <= snd_din;
        cycles    <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // External memories answer one cycle after their chip select
    always @(posedge clk) begin
        if (rom_cs) ext_din <= mem_word(3'd0, mem_addr);
        else if (ram_cs) ext_din <= mem_word(3'd1, mem_addr);
        else if (pal_cs) ext_din <= mem_word(3'd2, mem_addr);
        else if (obj_cs) ext_din <= mem_word(3'd3, mem_addr);
        else if (sub_cs) ext_din <= mem_word(3'd5, mem_addr);
    end

    // All DUT outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (rd_valid) begin
                if (rd_q.size() == 0) begin
                    $display("rd_valid pulsed at %0t ns with no read outstanding", $time);
                    abort_run();
                end else if (due_q[0] != cycles) begin
                    $display("Read data returned at %0t ns on the wrong cycle", $time);
                    abort_run();
                end else begin
                    check_rdata(rdata, expected_rdata(rd_q.pop_front(), cab_q), "read data");
                    void'(due_q.pop_front());
                end
            end else if (due_q.size() != 0 && cycles >= due_q[0]) begin
                $display("No rd_valid for a read that was due at %0t ns", $time);
                abort_run();
            end
            // Sound strobes seen at the last edge
            if (snd_wr_s) m_reply = snd_din_s;
            if (snd_rd_s) begin
                check_byte(snd_dout, m_fifo.size() == 0 ? 8'hff : m_fifo.pop_front(),
                           "sound data");
            end
            check_ctrl(ctrl, m_ctrl);
            check_byte({7'b0, snd_pending}, {7'b0, m_fifo.size() != 0}, "snd_pending");
            check_byte({3'b000, rom_cs, ram_cs, pal_cs, obj_cs, sub_cs},
                       {3'b000, cs_for(stage1)}, "chip selects");
            check_byte({7'b0, obj_toggle},
                       {7'b0, stage1.acc && stage1.addr[23:20] == 4'h4 &&
                        stage1.addr[6:4] == 3'd7}, "obj_toggle");
            // Side effects of the access decoded this cycle
            if (stage1.acc && stage1.rnw) begin
                rd_q.push_back(stage1);
                due_q.push_back(cycles + 1);
            end else if (stage1.acc && stage1.addr[23:20] == 4'h4) begin
                if (stage1.addr[6:4] == 3'd1) begin
                    m_ctrl.video_en = stage1.dout[5];
                    m_ctrl.adc_ch   = stage1.dout[4:2];
                    m_ctrl.snd_rstb = stage1.dout[0];
                end else if (stage1.addr[6:4] == 3'd5 && m_fifo.size() < `SND_FIFO_DEPTH) begin
                    m_fifo.push_back(stage1.dout[7:0]);
                end
            end
        end
    end

    task automatic cpu_access(input logic rnw, input logic [23:1] addr, input logic [15:0] d);
        @(negedge clk);
        bus.acc  = 1'b1;
        bus.rnw  = rnw;
        bus.addr = addr;
        bus.dsn  = 2'($urandom());
        bus.dout = d;
    endtask

    task automatic bus_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            bus.acc = 1'b0;
        end
    endtask

    task automatic randomize_cab();
        cab.joystick = 8'($urandom());
        cab.start    = 1'($urandom());
        cab.coin     = 2'($urandom());
        cab.service  = 1'($urandom());
        cab.dip_test = 1'($urandom());
        cab.dipsw_a  = 8'($urandom());
        cab.dipsw_b  = 8'($urandom());
        cab.wheel    = 8'($urandom());
        cab.pedal    = 16'($urandom());
    endtask

    task automatic snd_read();
        @(negedge clk);
        snd_rd = 1'b1;
        @(negedge clk);
        snd_rd = 1'b0;
    endtask

    task automatic snd_write(input logic [7:0] b);
        @(negedge clk);
        snd_wr  = 1'b1;
        snd_din = b;
        @(negedge clk);
        snd_wr  = 1'b0;
    endtask

    initial begin
        logic [23:1] a;
        logic [15:0] d;
        void'($urandom(42580));
        rst     = 1'b1;
        bus     = '0;
        cab     = '0;
        snd_rd  = 1'b0;
        snd_wr  = 1'b0;
        snd_din = 8'h00;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Mostly back-to-back random reads over the whole map
        for (int i = 0; i < 300; i++) begin
            a = 23'($urandom());
            a[23:20] = ($urandom() % 4 == 0) ? 4'($urandom()) : 4'($urandom_range(0, 5));
            if (a[23:20] == 4'h4 && a[6:4] == 3'd7) a[6:4] = 3'd2;   // Toggles tested later
            if ($urandom() % 4 == 0) bus_idle(1);
            randomize_cab();
            cpu_access(1'b1, a, 16'($urandom()));
        end
        bus_idle(3);

        // Switch and DIP bytes
        for (int i = 0; i < 40; i++) begin
            for (int s = 0; s < 4; s++) begin
                randomize_cab();
                cpu_access(1'b1, io_addr(3'd0, 2'(s)), 16'h0000);
            end
        end
        bus_idle(3);

        // Control latch and ADC channels
        for (int ch = 0; ch < 8; ch++) begin
            d = 16'($urandom());
            d[4:2] = 3'(ch);
            cpu_access(1'b0, io_addr(3'd1, 2'($urandom())), d);
            for (int k = 0; k < 6; k++) begin
                randomize_cab();
                cpu_access(1'b1, io_addr(3'd3, 2'($urandom())), 16'h0000);
            end
        end
        cpu_access(1'b0, io_addr(3'd1, 2'd0), 16'h0021);   // Video on, sound running
        bus_idle(3);

        // Five commands into a four-deep FIFO
        for (int i = 0; i < 5; i++) begin
            cpu_access(1'b0, io_addr(3'd5, 2'($urandom())), 16'($urandom()));
        end
        cpu_access(1'b1, io_addr(3'd5, 2'd0), 16'h0000);
        bus_idle(3);
        for (int i = 0; i < 5; i++) begin
            snd_read();   // Last one finds the FIFO empty
        end
        bus_idle(2);
        cpu_access(1'b1, io_addr(3'd5, 2'd0), 16'h0000);
        bus_idle(3);

        // Reply byte and object buffer toggles
        snd_write(8'($urandom()));
        bus_idle(2);
        cpu_access(1'b1, io_addr(3'd6, 2'd0), 16'h0000);
        bus_idle(2);
        for (int i = 0; i < 6; i++) begin
            cpu_access(1'(i), io_addr(3'd7, 2'($urandom())), 16'($urandom()));
            bus_idle(1);
        end
        bus_idle(4);

        if (rd_q.size() != 0) begin
            $display("%0d reads never returned data", rd_q.size());
            abort_run();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- compile.f
+incdir+rtl
rtl/main_board_pkg.sv
rtl/main_bus_decode.sv
rtl/cab_io.sv
rtl/snd_cmd_fifo.sv
rtl/snd_port.sv
rtl/bus_read_mux.sv
rtl/main_board_top.sv
sim/main_board_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is 0 only on pass
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module main_board_tb \
    -f compile.f -o main_board_sim || exit 1
out=$(./obj_dir/main_board_sim)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1
